/* verilog/mul16_pkg.sv */
/*
 * Shared widths and word types for the pipelined 16x16 unsigned
 * multiplier. Operands split into bytes, four quarter products are
 * formed and summed by two 32-bit carry-lookahead adders.
 */
package mul16_pkg;

  // Operand and product widths
  localparam int OPERAND_W = 16;
  localparam int HALF_W    = OPERAND_W / 2;
  localparam int PRODUCT_W = 2 * OPERAND_W;

  // One 8x8 quarter product
  localparam int PP_W = 2 * HALF_W;

  // Lookahead grouping of the 32-bit adder
  localparam int CLA_GROUP_W = 4;
  localparam int CLA_GROUPS  = PRODUCT_W / CLA_GROUP_W;

  // Full multiplier operand
  typedef logic [OPERAND_W-1:0] operand_t;

  // High or low byte of an operand
  typedef logic [HALF_W-1:0] half_t;

  // Quarter product of two operand bytes
  typedef logic [PP_W-1:0] pp_t;

  // Full product, also the adder word
  typedef logic [PRODUCT_W-1:0] product_t;

endpackage

/* verilog/array_mult8.sv */
/*
 * Exact 8x8 unsigned carry-save array multiplier.
 * AND plane, rows of half and full adders in carry-save form,
 * and a final ripple row for the upper byte.
 */
`timescale 1ns/10ps

module array_mult8 import mul16_pkg::*; (
  input  half_t a,
  input  half_t b,
  output pp_t   p
);

  // AND plane, row i holds a & b[i]
  logic [HALF_W-1:0] pp_bit [HALF_W];

  // Sum and carry vectors leaving each adder row
  logic [HALF_W-1:0] s_row [HALF_W];
  logic [HALF_W-2:0] c_row [1:HALF_W-1];

  always_comb begin
    for (int i = 0; i < HALF_W; i++) begin
      pp_bit[i] = a & {HALF_W{b[i]}};
    end
  end

  always_comb begin
    logic x;
    logic y;
    logic z;

    s_row[0] = pp_bit[0];

    // First row has no incoming carries, half adders only
    for (int j = 0; j < HALF_W - 1; j++) begin
      x = s_row[0][j+1];
      z = pp_bit[1][j];
      s_row[1][j] = x ^ z;
      c_row[1][j] = x & z;
    end
    s_row[1][HALF_W-1] = pp_bit[1][HALF_W-1];

    // Full adder rows, carries saved into the next row
    for (int i = 2; i < HALF_W; i++) begin
      for (int j = 0; j < HALF_W - 1; j++) begin
        x = s_row[i-1][j+1];
        y = c_row[i-1][j];
        z = pp_bit[i][j];
        s_row[i][j] = x ^ y ^ z;
        c_row[i][j] = (x & y) | (x & z) | (y & z);
      end
      s_row[i][HALF_W-1] = pp_bit[i][HALF_W-1];
    end
  end

  always_comb begin
    logic x;
    logic y;
    logic rc;

    // Low byte falls out of the array one bit per row
    for (int i = 0; i < HALF_W; i++) begin
      p[i] = s_row[i][0];
    end

    // Upper byte, ripple over the last sum and carry vectors
    rc = 1'b0;
    for (int j = 0; j < HALF_W - 1; j++) begin
      x = s_row[HALF_W-1][j+1];
      y = c_row[HALF_W-1][j];
      p[HALF_W+j] = x ^ y ^ rc;
      rc = (x & y) | (rc & (x ^ y));
    end
    p[PP_W-1] = rc;
  end

endmodule

/* verilog/cla_group4.sv */
/*
 * 4-bit carry-lookahead group.
 * Forms the internal carries from the group carry-in and
 * produces the group's sum bits.
 */
`timescale 1ns/10ps

module cla_group4 import mul16_pkg::*; (
  input  logic [CLA_GROUP_W-1:0] p,
  input  logic [CLA_GROUP_W-1:0] g,
  input  logic                   c_in,
  output logic [CLA_GROUP_W-1:0] sum
);

  logic [CLA_GROUP_W-1:0] c;

  // Carry into each bit, all taken straight from c_in
  assign c[0] = c_in;
  assign c[1] = g[0] | (p[0] & c_in);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c_in);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) |
                (p[2] & p[1] & p[0] & c_in);

  assign sum = p ^ c;

endmodule

/* verilog/cla_adder32.sv */
/*
 * 32-bit two-level carry-lookahead adder.
 * Eight 4-bit groups, group carries from a second lookahead level.
 * Carry-in is zero and no carry-out is produced.
 */
`timescale 1ns/10ps

module cla_adder32 import mul16_pkg::*; (
  input  product_t a,
  input  product_t b,
  output product_t sum
);

  product_t p;
  product_t g;

  // Group terms, the top group needs none with no carry out
  logic [CLA_GROUPS-2:1] grp_p;
  logic [CLA_GROUPS-2:0] grp_g;

  // Carry into each group
  logic [CLA_GROUPS-1:0] grp_c;

  assign p = a ^ b;
  assign g = a & b;

  for (genvar k = 0; k < CLA_GROUPS - 1; k++) begin : g_terms
    // Bottom group has no carry-in to propagate
    if (k > 0) begin : g_prop
      assign grp_p[k] = &p[k*CLA_GROUP_W +: CLA_GROUP_W];
    end
    assign grp_g[k] = g[k*CLA_GROUP_W+3] |
                      (p[k*CLA_GROUP_W+3] & g[k*CLA_GROUP_W+2]) |
                      (p[k*CLA_GROUP_W+3] & p[k*CLA_GROUP_W+2] &
                       g[k*CLA_GROUP_W+1]) |
                      (p[k*CLA_GROUP_W+3] & p[k*CLA_GROUP_W+2] &
                       p[k*CLA_GROUP_W+1] & g[k*CLA_GROUP_W]);
  end

  // Second level, each carry is a flat OR of generate terms
  always_comb begin
    logic term;
    logic carry;

    grp_c[0] = 1'b0;
    for (int k = 1; k < CLA_GROUPS; k++) begin
      carry = 1'b0;
      for (int j = 0; j < k; j++) begin
        term = grp_g[j];
        for (int m = j + 1; m < k; m++) begin
          term = term & grp_p[m];
        end
        carry = carry | term;
      end
      grp_c[k] = carry;
    end
  end

  for (genvar k = 0; k < CLA_GROUPS; k++) begin : g_group
    cla_group4 i_group (
      .p    (p[k*CLA_GROUP_W +: CLA_GROUP_W]),
      .g    (g[k*CLA_GROUP_W +: CLA_GROUP_W]),
      .c_in (grp_c[k]),
      .sum  (sum[k*CLA_GROUP_W +: CLA_GROUP_W])
    );
  end

endmodule

/* verilog/partial_product_stage.sv */
/*
 * First pipeline stage of the 16x16 multiplier.
 * Splits the operands into bytes, forms the four quarter
 * products and registers them with the valid strobe.
 */
`timescale 1ns/10ps

module partial_product_stage import mul16_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  operand_t a,
  input  operand_t b,
  output logic     pp_valid,
  output pp_t      pp_ll,
  output pp_t      pp_lh,
  output pp_t      pp_hl,
  output pp_t      pp_hh
);

  half_t a_lo;
  half_t a_hi;
  half_t b_lo;
  half_t b_hi;

  pp_t ll;
  pp_t lh;
  pp_t hl;
  pp_t hh;

  assign a_lo = a[HALF_W-1:0];
  assign a_hi = a[OPERAND_W-1:HALF_W];
  assign b_lo = b[HALF_W-1:0];
  assign b_hi = b[OPERAND_W-1:HALF_W];

  array_mult8 i_mult_ll (.a(a_lo), .b(b_lo), .p(ll));
  array_mult8 i_mult_lh (.a(a_lo), .b(b_hi), .p(lh));
  array_mult8 i_mult_hl (.a(a_hi), .b(b_lo), .p(hl));
  array_mult8 i_mult_hh (.a(a_hi), .b(b_hi), .p(hh));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pp_valid <= 1'b0;
    end else begin
      pp_valid <= in_valid;
    end
  end

  // Quarter products load only with a new operation
  always_ff @(posedge clk) begin
    if (in_valid) begin
      pp_ll <= ll;
      pp_lh <= lh;
      pp_hl <= hl;
      pp_hh <= hh;
    end
  end

endmodule

/* verilog/product_sum_stage.sv */
/*
 * Second pipeline stage of the 16x16 multiplier.
 * Aligns the quarter products, sums them with two lookahead
 * adders and registers the product.
 */
`timescale 1ns/10ps

module product_sum_stage import mul16_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     pp_valid,
  input  pp_t      pp_ll,
  input  pp_t      pp_lh,
  input  pp_t      pp_hl,
  input  pp_t      pp_hh,
  output logic     out_valid,
  output product_t product
);

  product_t word_llhh;
  product_t word_lh;
  product_t word_hl;
  product_t mid_sum;
  product_t full_sum;

  // High and low quarters do not overlap, so they share one word
  assign word_llhh = {pp_hh, pp_ll};
  assign word_lh   = {{HALF_W{1'b0}}, pp_lh, {HALF_W{1'b0}}};
  assign word_hl   = {{HALF_W{1'b0}}, pp_hl, {HALF_W{1'b0}}};

  cla_adder32 i_add_lh (.a(word_llhh), .b(word_lh), .sum(mid_sum));
  cla_adder32 i_add_hl (.a(mid_sum), .b(word_hl), .sum(full_sum));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pp_valid) begin
      product <= full_sum;
    end
  end

endmodule

/* verilog/mul16u_pipe.sv */
/*
 * Pipelined 16x16 unsigned multiplier, two register stages.
 * Product appears with out_valid two cycles after in_valid.
 */
`timescale 1ns/10ps

module mul16u_pipe import mul16_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  operand_t a,
  input  operand_t b,
  output logic     out_valid,
  output product_t product
);

  logic pp_valid;
  pp_t  pp_ll;
  pp_t  pp_lh;
  pp_t  pp_hl;
  pp_t  pp_hh;

  partial_product_stage i_pp_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .pp_valid (pp_valid),
    .pp_ll    (pp_ll),
    .pp_lh    (pp_lh),
    .pp_hl    (pp_hl),
    .pp_hh    (pp_hh)
  );

  product_sum_stage i_sum_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .pp_valid  (pp_valid),
    .pp_ll     (pp_ll),
    .pp_lh     (pp_lh),
    .pp_hl     (pp_hl),
    .pp_hh     (pp_hh),
    .out_valid (out_valid),
    .product   (product)
  );

endmodule

/* dv/tb_clock_gen.sv */
/*
 * Testbench clock and reset generator.
 * Free-running clock, rst_n held low for a number of cycles
 * and released on a falling edge.
 */
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* dv/mul16u_pipe_tb.sv */
/*
 * Testbench for the pipelined 16x16 unsigned multiplier.
 * Idle check after reset, a table of corner and lookahead cases,
 * then seeded random traffic against a two-cycle reference model.
 */
`timescale 1ns/10ps

module mul16u_pipe_tb import mul16_pkg::*;;

  localparam int CLK_PERIOD_NS   = 4;
  localparam int RESET_CYCLES    = 8;
  localparam int IDLE_CYCLES     = 10;
  localparam int TABLE_LEN       = 20;
  localparam int RAND_COUNT      = 300;
  localparam int WATCHDOG_CYCLES = (TABLE_LEN + RAND_COUNT + 20) * 2;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  operand_t a;
  operand_t b;
  logic     out_valid;
  product_t product;

  // Stimulus table
  string    tab_name [TABLE_LEN];
  operand_t tab_a    [TABLE_LEN];
  operand_t tab_b    [TABLE_LEN];
  logic     tab_vld  [TABLE_LEN];
  product_t tab_exp  [TABLE_LEN];

  // Reference pipeline, one slot per cycle plus results still pending
  logic     valid_hist [$];
  string    name_hist  [$];
  product_t exp_q      [$];
  string    exp_name_q [$];

  integer seed;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mul16u_pipe i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  task automatic stop_on_error();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_product(input string name, input product_t exp, input product_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s product: expected 0x%08h, actual 0x%08h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s out_valid: expected %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic set_entry(input int idx, input string name, input operand_t op_a,
                           input operand_t op_b, input logic vld, input product_t exp);
    tab_name[idx] = name;
    tab_a[idx]    = op_a;
    tab_b[idx]    = op_b;
    tab_vld[idx]  = vld;
    tab_exp[idx]  = exp;
  endtask

  // Expected values are the plain integer products
  task automatic fill_table();
    set_entry(0,  "zero_x",        16'h0000, 16'h1234, 1'b1, 32'h0000_0000);
    set_entry(1,  "x_zero",        16'habcd, 16'h0000, 1'b1, 32'h0000_0000);
    set_entry(2,  "one_x",         16'h0001, 16'hbeef, 1'b1, 32'h0000_beef);
    set_entry(3,  "x_one",         16'hffff, 16'h0001, 1'b1, 32'h0000_ffff);
    set_entry(4,  "gap_0",         16'h5a5a, 16'ha5a5, 1'b0, 32'h0000_0000);
    set_entry(5,  "ff_ff",         16'h00ff, 16'h00ff, 1'b1, 32'h0000_fe01);
    set_entry(6,  "ff00_ff",       16'hff00, 16'h00ff, 1'b1, 32'h00fe_0100);
    set_entry(7,  "ff_ff00",       16'h00ff, 16'hff00, 1'b1, 32'h00fe_0100);
    set_entry(8,  "ff00_ff00",     16'hff00, 16'hff00, 1'b1, 32'hfe01_0000);
    set_entry(9,  "max_max",       16'hffff, 16'hffff, 1'b1, 32'hfffe_0001);
    set_entry(10, "gap_1",         16'hffff, 16'hffff, 1'b0, 32'h0000_0000);
    set_entry(11, "gap_2",         16'h0000, 16'h0000, 1'b0, 32'h0000_0000);
    // Middle products rippling through several 4-bit groups
    set_entry(12, "cla_0fff_f0ff", 16'h0fff, 16'hf0ff, 1'b1, 32'h0f0e_ff01);
    set_entry(13, "cla_80ff_ff80", 16'h80ff, 16'hff80, 1'b1, 32'h80be_8080);
    set_entry(14, "cla_ffff_0101", 16'hffff, 16'h0101, 1'b1, 32'h0100_feff);
    set_entry(15, "cla_fff0_0fff", 16'hfff0, 16'h0fff, 1'b1, 32'h0ffe_0010);
    set_entry(16, "mid_7fff",      16'h7fff, 16'h7fff, 1'b1, 32'h3fff_0001);
    set_entry(17, "msb_8000",      16'h8000, 16'h8000, 1'b1, 32'h4000_0000);
    set_entry(18, "mixed",         16'h1234, 16'h5678, 1'b1, 32'h0626_0060);
    set_entry(19, "mid_0ff0",      16'h0ff0, 16'h0ff0, 1'b1, 32'h00fe_0100);
  endtask

  // One clock cycle: check what left the pipe, then issue the next input
  task automatic apply_cycle(input string name, input operand_t op_a, input operand_t op_b,
                             input logic vld, input product_t exp);
    logic     exp_v;
    string    hist_name;
    product_t exp_p;
    string    exp_name;

    @(negedge clk);
    exp_v     = valid_hist.pop_front();
    hist_name = name_hist.pop_front();
    check_valid(hist_name, exp_v, out_valid);
    if (out_valid === 1'b1) begin
      exp_p    = exp_q.pop_front();
      exp_name = exp_name_q.pop_front();
      check_product(exp_name, exp_p, product);
    end

    in_valid = vld;
    a        = op_a;
    b        = op_b;
    valid_hist.push_back(vld);
    name_hist.push_back(name);
    if (vld) begin
      exp_q.push_back(exp);
      exp_name_q.push_back(name);
    end
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    operand_t    ra;
    operand_t    rb;
    logic        rv;
    product_t    exp;

    // Valid held high through reset, the pipe must still come out empty
    in_valid    = 1'b1;
    a           = '0;
    b           = '0;
    seed        = 32'hbfaf0106;
    fill_table();

    // Pipe is empty when reset ends
    for (int i = 0; i < 2; i++) begin
      valid_hist.push_back(1'b0);
      name_hist.push_back("reset");
    end

    wait (rst_n === 1'b1);
    in_valid = 1'b0;

    for (int i = 0; i < IDLE_CYCLES; i++) begin
      apply_cycle("idle", '0, '0, 1'b0, '0);
    end

    for (int i = 0; i < TABLE_LEN; i++) begin
      apply_cycle(tab_name[i], tab_a[i], tab_b[i], tab_vld[i], tab_exp[i]);
    end

    // Roughly three quarters of the cycles issue
    for (int i = 0; i < RAND_COUNT; i++) begin
      rnd = $random(seed);
      ra  = rnd[15:0];
      rb  = rnd[31:16];
      rnd = $random(seed);
      rv  = (rnd[1:0] != 2'b00);
      exp = product_t'(ra) * product_t'(rb);
      apply_cycle($sformatf("rand_%0d", i), ra, rb, rv, exp);
    end

    for (int i = 0; i < 2; i++) begin
      apply_cycle("drain", '0, '0, 1'b0, '0);
    end

    $display(">>> PASS");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    stop_on_error();
  end

endmodule

/* compile.f */
verilog/mul16_pkg.sv
verilog/array_mult8.sv
verilog/cla_group4.sv
verilog/cla_adder32.sv
verilog/partial_product_stage.sv
verilog/product_sum_stage.sv
verilog/mul16u_pipe.sv
dv/tb_clock_gen.sv
dv/mul16u_pipe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the multiplier testbench with Verilator.
# Exit status is zero only when the log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
TOP=mul16u_pipe_tb

rm -rf "$BUILD_DIR"

verilator --binary --timing \
  -f compile.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG_FILE"
  exit 1
fi
